//--- design/rs_alu.sv
`include "rs_defs.svh"

module rs_alu import rs_pkg::*; (
	input  logic        clk_in,
	input  logic        rob_rs_rst_in,

	// issue from the station, always accepted
	input  logic        iss_valid,
	input  opcode_e     iss_opcode,
	input  rob_tag_t    iss_dest,
	input  data_t       iss_a,
	input  data_t       iss_b,

	// result broadcast
	output logic        cdb_valid,
	output rob_tag_t    cdb_tag,
	output data_t       cdb_value
);

	// stage one holds the operation
	logic     s1_valid;
	opcode_e  s1_op;
	rob_tag_t s1_dest;
	data_t    s1_a;
	data_t    s1_b;

	data_t    result;

	always_ff @(posedge clk_in) begin
		if (rob_rs_rst_in) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= iss_valid;
		end
	end

	always_ff @(posedge clk_in) begin
		if (iss_valid) begin
			s1_op   <= iss_opcode;
			s1_dest <= iss_dest;
			s1_a    <= iss_a;
			s1_b    <= iss_b;
		end
	end

	always_comb begin
		case (s1_op)
			OP_ADD, OP_ADDI: result = s1_a + s1_b;
			OP_SUB:          result = s1_a - s1_b;
			OP_AND:          result = s1_a & s1_b;
			OP_OR:           result = s1_a | s1_b;
			OP_XOR:          result = s1_a ^ s1_b;
			OP_SLL:          result = s1_a << s1_b[4:0];
			OP_SRL:          result = s1_a >> s1_b[4:0];
			OP_SLT:          result = data_t'($signed(s1_a) < $signed(s1_b));
			// immediate already sits in b
			OP_LUI:          result = s1_b << 12;
			default:         result = '0;
		endcase
	end

	// stage two drives the CDB
	always_ff @(posedge clk_in) begin
		if (rob_rs_rst_in) begin
			cdb_valid <= 1'b0;
		end else begin
			cdb_valid <= s1_valid;
		end
	end

	always_ff @(posedge clk_in) begin
		if (s1_valid) begin
			cdb_tag   <= s1_dest;
			cdb_value <= result;
		end
	end

endmodule

//--- design/rs_dispatcher.sv
`include "rs_defs.svh"

module rs_dispatcher import rs_pkg::*; (
	input  logic        clk_in,
	input  logic        rob_rs_rst_in,

	// instruction input, four-phase req/ack
	input  logic        ins_req,
	output logic        ins_ack,
	input  opcode_e     ins_opcode,
	input  rob_tag_t    ins_dest,
	input  rob_tag_t    ins_qj,
	input  rob_tag_t    ins_qk,
	input  data_t       ins_vj,
	input  data_t       ins_vk,
	input  data_t       ins_imm,

	// station write port
	input  logic        st_free,
	output logic        st_wr,
	output opcode_e     st_opcode,
	output rob_tag_t    st_dest,
	output rob_tag_t    st_qj,
	output data_t       st_vj,
	output rob_tag_t    st_qk,
	output data_t       st_vk
);

	disp_state_e state;
	disp_state_e next_state;

	// one write per request, only while a slot is free
	assign st_wr = (state == DS_IDLE) && ins_req && st_free;

	// ack stays up until the producer has dropped its request
	assign ins_ack = (state == DS_ACK);

	always_comb begin
		next_state = state;
		case (state)
			DS_IDLE: begin
				if (st_wr) begin
					next_state = DS_ACK;
				end
			end
			DS_ACK: begin
				if (!ins_req) begin
					next_state = DS_IDLE;
				end
			end
			default: begin
				next_state = DS_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk_in) begin
		if (rob_rs_rst_in) begin
			state <= DS_IDLE;
		end else begin
			state <= next_state;
		end
	end

	// operand forming
	always_comb begin
		st_opcode = ins_opcode;
		st_dest   = ins_dest;
		st_qj     = ins_qj;
		st_vj     = ins_vj;
		st_qk     = ins_qk;
		st_vk     = ins_vk;
		case (ins_opcode)
			OP_ADDI: begin
				// rs2 is replaced by the immediate
				st_qk = '0;
				st_vk = ins_imm;
			end
			OP_LUI: begin
				// no register source at all
				st_qj = '0;
				st_qk = '0;
				st_vk = ins_imm;
			end
			default: begin
			end
		endcase
	end

endmodule

//--- design/rs_pkg.sv
`include "rs_defs.svh"

package rs_pkg;

	// operand, result and tag types
	typedef logic [`RS_DATA_W-1:0] data_t;
	typedef logic [`RS_TAG_W-1:0] rob_tag_t;

	// integer operations handled by the issue stage
	typedef enum logic [`RS_OP_W-1:0] {
		OP_ADD  = 4'd0,
		OP_SUB  = 4'd1,
		OP_AND  = 4'd2,
		OP_OR   = 4'd3,
		OP_XOR  = 4'd4,
		OP_SLL  = 4'd5,
		OP_SRL  = 4'd6,
		OP_SLT  = 4'd7,
		// immediate forms, the immediate lands in the second operand
		OP_ADDI = 4'd8,
		OP_LUI  = 4'd9
	} opcode_e;

	// receiving side of the four-phase handshake
	typedef enum logic {
		DS_IDLE = 1'b0,
		DS_ACK  = 1'b1
	} disp_state_e;

endpackage

//--- design/rs_station.sv
`include "rs_defs.svh"

module rs_station import rs_pkg::*; (
	input  logic        clk_in,
	input  logic        rob_rs_rst_in,

	// write port from the dispatcher
	input  logic        st_wr,
	input  opcode_e     st_opcode,
	input  rob_tag_t    st_dest,
	input  rob_tag_t    st_qj,
	input  data_t       st_vj,
	input  rob_tag_t    st_qk,
	input  data_t       st_vk,
	output logic        st_free,

	// common data bus snoop
	input  logic        cdb_valid,
	input  rob_tag_t    cdb_tag,
	input  data_t       cdb_value,

	// issue to the ALU
	output logic        iss_valid,
	output opcode_e     iss_opcode,
	output rob_tag_t    iss_dest,
	output data_t       iss_a,
	output data_t       iss_b
);

	localparam int IDX_W = $clog2(`RS_COUNT);

	logic [`RS_COUNT-1:0] busy;
	opcode_e  ent_op   [0:`RS_COUNT-1];
	rob_tag_t ent_dest [0:`RS_COUNT-1];
	rob_tag_t ent_qj   [0:`RS_COUNT-1];
	data_t    ent_vj   [0:`RS_COUNT-1];
	rob_tag_t ent_qk   [0:`RS_COUNT-1];
	data_t    ent_vk   [0:`RS_COUNT-1];

	logic [`RS_COUNT-1:0] ready;
	logic [IDX_W-1:0]     free_idx;
	logic [IDX_W-1:0]     iss_idx;
	logic                 iss_hit;
	logic                 cdb_hit;

	// operands of the incoming entry after the write-time bypass
	rob_tag_t wr_qj;
	data_t    wr_vj;
	rob_tag_t wr_qk;
	data_t    wr_vk;

	assign st_free = ~&busy;
	assign cdb_hit = cdb_valid && (cdb_tag != '0);

	// lowest empty slot
	always_comb begin
		free_idx = '0;
		for (int i = `RS_COUNT - 1; i >= 0; i--) begin
			if (!busy[i]) begin
				free_idx = IDX_W'(i);
			end
		end
	end

	// lowest entry with both operands present wins the issue slot
	always_comb begin
		iss_idx = '0;
		for (int i = 0; i < `RS_COUNT; i++) begin
			ready[i] = busy[i] && (ent_qj[i] == '0) && (ent_qk[i] == '0);
		end
		for (int i = `RS_COUNT - 1; i >= 0; i--) begin
			if (ready[i]) begin
				iss_idx = IDX_W'(i);
			end
		end
	end

	assign iss_hit = |ready;

	// a result broadcast on the write edge is caught here
	always_comb begin
		wr_qj = st_qj;
		wr_vj = st_vj;
		wr_qk = st_qk;
		wr_vk = st_vk;
		if (cdb_hit && (st_qj == cdb_tag)) begin
			wr_qj = '0;
			wr_vj = cdb_value;
		end
		if (cdb_hit && (st_qk == cdb_tag)) begin
			wr_qk = '0;
			wr_vk = cdb_value;
		end
	end

	// occupancy and issue strobe
	always_ff @(posedge clk_in) begin
		if (rob_rs_rst_in) begin
			busy      <= '0;
			iss_valid <= 1'b0;
		end else begin
			iss_valid <= iss_hit;
			if (iss_hit) begin
				busy[iss_idx] <= 1'b0;
			end
			// the free slot is never the issuing one
			if (st_wr) begin
				busy[free_idx] <= 1'b1;
			end
		end
	end

	// entry payload, wakeup and issue operands
	always_ff @(posedge clk_in) begin
		for (int i = 0; i < `RS_COUNT; i++) begin
			if (busy[i] && cdb_hit) begin
				if (ent_qj[i] == cdb_tag) begin
					ent_qj[i] <= '0;
					ent_vj[i] <= cdb_value;
				end
				if (ent_qk[i] == cdb_tag) begin
					ent_qk[i] <= '0;
					ent_vk[i] <= cdb_value;
				end
			end
		end
		if (st_wr) begin
			ent_op[free_idx]   <= st_opcode;
			ent_dest[free_idx] <= st_dest;
			ent_qj[free_idx]   <= wr_qj;
			ent_vj[free_idx]   <= wr_vj;
			ent_qk[free_idx]   <= wr_qk;
			ent_vk[free_idx]   <= wr_vk;
		end
		if (iss_hit) begin
			iss_opcode <= ent_op[iss_idx];
			iss_dest   <= ent_dest[iss_idx];
			iss_a      <= ent_vj[iss_idx];
			iss_b      <= ent_vk[iss_idx];
		end
	end

endmodule

//--- design/rs_top.sv
module rs_top import rs_pkg::*; (
	input  logic        clk_in,
	input  logic        rob_rs_rst_in,

	// instruction input
	input  logic        ins_req,
	output logic        ins_ack,
	input  opcode_e     ins_opcode,
	input  rob_tag_t    ins_dest,
	input  rob_tag_t    ins_qj,
	input  rob_tag_t    ins_qk,
	input  data_t       ins_vj,
	input  data_t       ins_vk,
	input  data_t       ins_imm,

	// CDB export
	output logic        cdb_valid,
	output rob_tag_t    cdb_tag,
	output data_t       cdb_value
);

	// dispatcher to station
	logic     st_wr;
	logic     st_free;
	opcode_e  st_opcode;
	rob_tag_t st_dest;
	rob_tag_t st_qj;
	data_t    st_vj;
	rob_tag_t st_qk;
	data_t    st_vk;

	// station to ALU
	logic     iss_valid;
	opcode_e  iss_opcode;
	rob_tag_t iss_dest;
	data_t    iss_a;
	data_t    iss_b;

	rs_dispatcher dispatcher_i (
		.clk_in        (clk_in),
		.rob_rs_rst_in (rob_rs_rst_in),
		.ins_req       (ins_req),
		.ins_ack       (ins_ack),
		.ins_opcode    (ins_opcode),
		.ins_dest      (ins_dest),
		.ins_qj        (ins_qj),
		.ins_qk        (ins_qk),
		.ins_vj        (ins_vj),
		.ins_vk        (ins_vk),
		.ins_imm       (ins_imm),
		.st_free       (st_free),
		.st_wr         (st_wr),
		.st_opcode     (st_opcode),
		.st_dest       (st_dest),
		.st_qj         (st_qj),
		.st_vj         (st_vj),
		.st_qk         (st_qk),
		.st_vk         (st_vk)
	);

	// the ALU result loops back for operand wakeup
	rs_station station_i (
		.clk_in        (clk_in),
		.rob_rs_rst_in (rob_rs_rst_in),
		.st_wr         (st_wr),
		.st_opcode     (st_opcode),
		.st_dest       (st_dest),
		.st_qj         (st_qj),
		.st_vj         (st_vj),
		.st_qk         (st_qk),
		.st_vk         (st_vk),
		.st_free       (st_free),
		.cdb_valid     (cdb_valid),
		.cdb_tag       (cdb_tag),
		.cdb_value     (cdb_value),
		.iss_valid     (iss_valid),
		.iss_opcode    (iss_opcode),
		.iss_dest      (iss_dest),
		.iss_a         (iss_a),
		.iss_b         (iss_b)
	);

	rs_alu alu_i (
		.clk_in        (clk_in),
		.rob_rs_rst_in (rob_rs_rst_in),
		.iss_valid     (iss_valid),
		.iss_opcode    (iss_opcode),
		.iss_dest      (iss_dest),
		.iss_a         (iss_a),
		.iss_b         (iss_b),
		.cdb_valid     (cdb_valid),
		.cdb_tag       (cdb_tag),
		.cdb_value     (cdb_value)
	);

endmodule

//--- include/rs_defs.svh
`ifndef RS_DEFS_SVH
`define RS_DEFS_SVH

// operand and result width
`define RS_DATA_W 32

// reorder-buffer tag width, tag 0 means the operand is already a value
`define RS_TAG_W 4

// station depth, anything from 2 to 8 works
`define RS_COUNT 4

// opcode field width
`define RS_OP_W 4

`endif

//--- tb/rs_checker.sv
module rs_checker import rs_pkg::*; (
	input  logic     clk_in,
	input  logic     rob_rs_rst_in,
	input  logic     ins_req,
	input  logic     ins_ack,
	input  logic     iss_valid,
	input  logic     cdb_valid,
	input  rob_tag_t cdb_tag
);

	timeunit 1ns;
	timeprecision 100ps;

	// ack only answers a request that was up on the previous edge
	ack_rise_a: assert property (@(posedge clk_in) disable iff (rob_rs_rst_in)
		$rose(ins_ack) |-> $past(ins_req))
		else $error("ins_ack rose without a pending request");

	// ack is held until the request has gone away
	ack_fall_a: assert property (@(posedge clk_in) disable iff (rob_rs_rst_in)
		$fell(ins_ack) |-> !$past(ins_req))
		else $error("ins_ack fell while the request was still high");

	ctag_nonzero_a: assert property (@(posedge clk_in) disable iff (rob_rs_rst_in)
		cdb_valid |-> (cdb_tag != '0))
		else $error("CDB broadcast carries tag zero");

	// two-stage ALU, fixed latency in both directions
	iss_to_cdb_a: assert property (@(posedge clk_in) disable iff (rob_rs_rst_in)
		iss_valid |-> ##2 cdb_valid)
		else $error("issue was not followed by a CDB broadcast two cycles later");

	cdb_from_iss_a: assert property (@(posedge clk_in) disable iff (rob_rs_rst_in)
		cdb_valid |-> $past(iss_valid, 2))
		else $error("CDB broadcast without an issue two cycles earlier");

endmodule

bind rs_top rs_checker checker_i (
	.clk_in        (clk_in),
	.rob_rs_rst_in (rob_rs_rst_in),
	.ins_req       (ins_req),
	.ins_ack       (ins_ack),
	.iss_valid     (iss_valid),
	.cdb_valid     (cdb_valid),
	.cdb_tag       (cdb_tag)
);

//--- tb/rs_tb.sv
`include "rs_defs.svh"

module rs_tb import rs_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int ROWS         = 18;
	localparam int GAP_MAX      = 7;
	localparam int DRAIN_CYCLES = 20;
	localparam int RST_CYCLES   = 10;
	localparam int MAX_INFLIGHT = `RS_COUNT + 2;
	localparam int TAGS         = 1 << `RS_TAG_W;
	localparam int WATCH_CYCLES = ROWS * (GAP_MAX + DRAIN_CYCLES) + RST_CYCLES;

	typedef struct packed {
		opcode_e  op;
		rob_tag_t dest;
		rob_tag_t qj;
		data_t    vj;
		rob_tag_t qk;
		data_t    vk;
		data_t    imm;
		logic     burst;
		data_t    exp;
	} row_t;

	logic     clk_in;
	logic     rob_rs_rst_in;
	logic     ins_req;
	logic     ins_ack;
	opcode_e  ins_opcode;
	rob_tag_t ins_dest;
	rob_tag_t ins_qj;
	rob_tag_t ins_qk;
	data_t    ins_vj;
	data_t    ins_vk;
	data_t    ins_imm;
	logic     cdb_valid;
	rob_tag_t cdb_tag;
	data_t    cdb_value;

	row_t        rows [ROWS];
	data_t       exp_of_tag [TAGS];
	logic        outstanding [TAGS];
	logic        completed [TAGS];
	int          inflight;
	int          seen_cnt;
	logic [31:0] lfsr;

	rs_top dut_i (
		.clk_in        (clk_in),
		.rob_rs_rst_in (rob_rs_rst_in),
		.ins_req       (ins_req),
		.ins_ack       (ins_ack),
		.ins_opcode    (ins_opcode),
		.ins_dest      (ins_dest),
		.ins_qj        (ins_qj),
		.ins_qk        (ins_qk),
		.ins_vj        (ins_vj),
		.ins_vk        (ins_vk),
		.ins_imm       (ins_imm),
		.cdb_valid     (cdb_valid),
		.cdb_tag       (cdb_tag),
		.cdb_value     (cdb_value)
	);

	initial begin
		clk_in = 1'b0;
		forever #5 clk_in = ~clk_in;
	end

	// galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	task automatic draw_gap(output int gap);
		gap = 0;
		for (int b = 0; b < 3; b++) begin
			gap = gap | (int'(lfsr[0]) << b);
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// integer result rules of the issue stage
	function automatic data_t alu_model(input opcode_e op, input data_t a, input data_t b);
		data_t r;
		r = '0;
		case (op)
			OP_ADD, OP_ADDI: r = a + b;
			OP_SUB:          r = a - b;
			OP_AND:          r = a & b;
			OP_OR:           r = a | b;
			OP_XOR:          r = a ^ b;
			OP_SLL:          r = a << b[4:0];
			OP_SRL:          r = a >> b[4:0];
			OP_SLT:          r = ($signed(a) < $signed(b)) ? data_t'(1) : '0;
			OP_LUI:          r = {b[`RS_DATA_W-13:0], 12'h000};
			default:         r = '0;
		endcase
		return r;
	endfunction

	task automatic load_table();
		// op, dest, qj, vj, qk, vk, imm, burst, exp (filled by the model)
		rows[0]  = '{OP_ADD,  4'd1,  4'd0,  32'h0000_1234, 4'd0,  32'h0000_0f0f, 32'h0, 1'b0, 32'h0};
		rows[1]  = '{OP_SUB,  4'd2,  4'd0,  32'h0000_0010, 4'd0,  32'h0000_0030, 32'h0, 1'b0, 32'h0};
		rows[2]  = '{OP_AND,  4'd3,  4'd0,  32'hf0f0_f0f0, 4'd0,  32'h3c3c_3c3c, 32'h0, 1'b0, 32'h0};
		rows[3]  = '{OP_OR,   4'd4,  4'd0,  32'h1200_0000, 4'd0,  32'h0000_0034, 32'h0, 1'b0, 32'h0};
		rows[4]  = '{OP_XOR,  4'd5,  4'd0,  32'hffff_0000, 4'd0,  32'h0f0f_0f0f, 32'h0, 1'b0, 32'h0};
		rows[5]  = '{OP_SLL,  4'd6,  4'd0,  32'h0000_0003, 4'd0,  32'h0000_0024, 32'h0, 1'b0, 32'h0};
		rows[6]  = '{OP_SRL,  4'd7,  4'd0,  32'h8000_0000, 4'd0,  32'hffff_ffff, 32'h0, 1'b0, 32'h0};
		rows[7]  = '{OP_SLT,  4'd8,  4'd0,  32'hffff_fffe, 4'd0,  32'h0000_0001, 32'h0, 1'b0, 32'h0};
		// register tags on LUI point at results that only come much later
		rows[8]  = '{OP_LUI,  4'd9,  4'd14, 32'hdead_beef, 4'd15, 32'h1111_1111,
			32'h000a_bcde, 1'b0, 32'h0};
		// dependent chain, sent back to back
		rows[9]  = '{OP_ADD,  4'd10, 4'd1,  32'h0,         4'd2,  32'h0,         32'h0, 1'b0, 32'h0};
		rows[10] = '{OP_ADDI, 4'd11, 4'd10, 32'h0,         4'd15, 32'h2222_2222,
			32'h0000_0100, 1'b1, 32'h0};
		rows[11] = '{OP_XOR,  4'd12, 4'd11, 32'h0,         4'd10, 32'h0,         32'h0, 1'b1, 32'h0};
		rows[12] = '{OP_SUB,  4'd13, 4'd12, 32'h0,         4'd9,  32'h0,         32'h0, 1'b1, 32'h0};
		// waiters on the end of the chain fill the station
		rows[13] = '{OP_OR,   4'd14, 4'd13, 32'h0,         4'd0,  32'h0000_0f00, 32'h0, 1'b1, 32'h0};
		rows[14] = '{OP_SLT,  4'd15, 4'd13, 32'h0,         4'd12, 32'h0,         32'h0, 1'b1, 32'h0};
		rows[15] = '{OP_AND,  4'd1,  4'd13, 32'h0,         4'd14, 32'h0,         32'h0, 1'b1, 32'h0};
		rows[16] = '{OP_ADD,  4'd2,  4'd13, 32'h0,         4'd0,  32'h0000_0005, 32'h0, 1'b1, 32'h0};
		// the last waiter finds the station full and stalls
		rows[17] = '{OP_XOR,  4'd3,  4'd13, 32'h0,         4'd15, 32'h0,         32'h0, 1'b1, 32'h0};
	endtask

	// reference model, earlier results stand in for named tags
	task automatic build_expected();
		data_t ref_val [TAGS];
		data_t a;
		data_t b;
		for (int t = 0; t < TAGS; t++) begin
			ref_val[t] = '0;
		end
		for (int i = 0; i < ROWS; i++) begin
			a = (rows[i].qj != '0) ? ref_val[rows[i].qj] : rows[i].vj;
			b = (rows[i].qk != '0) ? ref_val[rows[i].qk] : rows[i].vk;
			if (rows[i].op == OP_ADDI || rows[i].op == OP_LUI) begin
				b = rows[i].imm;
			end
			if (rows[i].op == OP_LUI) begin
				a = '0;
			end
			rows[i].exp = alu_model(rows[i].op, a, b);
			ref_val[rows[i].dest] = rows[i].exp;
		end
	endtask

	task automatic stop_failed(input string line);
		$display("%s", line);
		$display("Simulation FAILED");
		$fatal(1, "stopping after the first failure");
	endtask

	task automatic check_tag(input rob_tag_t got);
		if (got == '0 || outstanding[got] !== 1'b1) begin
			stop_failed($sformatf("ERROR at %0d ns: CDB tag %0d is not outstanding",
				$time, got));
		end
	endtask

	task automatic check_value(input data_t got, input data_t exp, input string what);
		if (got !== exp) begin
			stop_failed($sformatf("ERROR at %0d ns: %s got %h, expected %h",
				$time, what, got, exp));
		end
	endtask

	task automatic check_level(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			stop_failed($sformatf("ERROR at %0d ns: %s is %b, expected %b",
				$time, what, got, exp));
		end
	endtask

	// operand forwarding the way a reorder buffer would supply it
	task automatic resolve_operand(input rob_tag_t q, input data_t v,
		output rob_tag_t q_out, output data_t v_out);
		logic on_bus;
		on_bus = (cdb_valid === 1'b1) && (cdb_tag == q);
		q_out = q;
		v_out = v;
		if (q == '0) begin
			q_out = '0;
		end else if (on_bus && dut_i.st_free) begin
			// written on the broadcast edge, caught by the bypass
			q_out = q;
		end else if (on_bus || completed[q]) begin
			q_out = '0;
			v_out = exp_of_tag[q];
		end
	endtask

	task automatic send_row(input int i);
		int       gap;
		int       pending;
		rob_tag_t qj;
		data_t    vj;
		rob_tag_t qk;
		data_t    vk;
		gap = 0;
		if (!rows[i].burst) begin
			draw_gap(gap);
		end
		repeat (gap) @(negedge clk_in);
		// a reused tag waits for its earlier owner
		while (outstanding[rows[i].dest] === 1'b1) @(negedge clk_in);
		resolve_operand(rows[i].qj, rows[i].vj, qj, vj);
		resolve_operand(rows[i].qk, rows[i].vk, qk, vk);
		exp_of_tag[rows[i].dest] = rows[i].exp;
		completed[rows[i].dest]  = 1'b0;
		ins_opcode = rows[i].op;
		ins_dest   = rows[i].dest;
		ins_qj     = qj;
		ins_vj     = vj;
		ins_qk     = qk;
		ins_vk     = vk;
		ins_imm    = rows[i].imm;
		ins_req    = 1'b1;
		@(negedge clk_in);
		while (ins_ack !== 1'b1) @(negedge clk_in);
		outstanding[rows[i].dest] = 1'b1;
		inflight++;
		// a result on the bus right now has already left the pipeline
		pending = inflight;
		if (cdb_valid === 1'b1 && outstanding[cdb_tag] === 1'b1) begin
			pending--;
		end
		if (pending > MAX_INFLIGHT) begin
			stop_failed($sformatf("ERROR at %0d ns: %0d instructions in flight, limit %0d",
				$time, pending, MAX_INFLIGHT));
		end
		ins_req = 1'b0;
		@(negedge clk_in);
		while (ins_ack !== 1'b0) @(negedge clk_in);
	endtask

	// CDB monitor
	always @(negedge clk_in) begin
		if (cdb_valid === 1'b1) begin
			check_tag(cdb_tag);
			check_value(cdb_value, exp_of_tag[cdb_tag], $sformatf("CDB value of tag %0d", cdb_tag));
			outstanding[cdb_tag] = 1'b0;
			completed[cdb_tag]   = 1'b1;
			seen_cnt++;
			inflight--;
		end
	end

	initial begin
		#(WATCH_CYCLES * 10);
		stop_failed("The run timed out before every instruction was broadcast on the CDB.");
	end

	initial begin
		rob_rs_rst_in = 1'b1;
		ins_req       = 1'b0;
		ins_opcode    = OP_ADD;
		ins_dest      = '0;
		ins_qj        = '0;
		ins_qk        = '0;
		ins_vj        = '0;
		ins_vk        = '0;
		ins_imm       = '0;
		lfsr          = 32'h82d4_d9de;
		inflight      = 0;
		seen_cnt      = 0;
		for (int t = 0; t < TAGS; t++) begin
			exp_of_tag[t]  = '0;
			outstanding[t] = 1'b0;
			completed[t]   = 1'b0;
		end
		load_table();
		build_expected();

		for (int c = 0; c < RST_CYCLES; c++) begin
			@(negedge clk_in);
			check_level(ins_ack, 1'b0, "ins_ack during reset");
			check_level(cdb_valid, 1'b0, "cdb_valid during reset");
		end
		rob_rs_rst_in = 1'b0;
		@(negedge clk_in);
		check_level(ins_ack, 1'b0, "ins_ack after reset");
		check_level(cdb_valid, 1'b0, "cdb_valid after reset");

		for (int i = 0; i < ROWS; i++) begin
			send_row(i);
		end
		while (seen_cnt < ROWS) @(negedge clk_in);
		// quiet period, a repeated broadcast would show up here
		repeat (DRAIN_CYCLES) @(negedge clk_in);

		if (seen_cnt == ROWS && inflight == 0) begin
			$display("Simulation PASSED");
			$finish;
		end else begin
			stop_failed("Some instructions were broadcast more than once or never completed.");
		end
	end

endmodule

//--- vlog.f
+incdir+include
design/rs_pkg.sv
design/rs_dispatcher.sv
design/rs_station.sv
design/rs_alu.sv
design/rs_top.sv
tb/rs_checker.sv
tb/rs_tb.sv
